//--- rv_defs.svh
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// Data word and address width
`define RV_XLEN 64

// Instruction width as fetched from memory
`define RV_ILEN 32

// First fetch address after reset
`define RV_RESET_PC 64'h0000_0000_0000_0000

// Architectural integer registers
`define RV_NREGS 32

`endif

//--- rv_pkg.sv
`include "rv_defs.svh"

package rv_pkg;

    typedef logic [`RV_XLEN-1:0] xlen_t;
    typedef logic [`RV_ILEN-1:0] instr_t;
    typedef logic [$clog2(`RV_NREGS)-1:0] reg_idx_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        // Operand b straight through, for LUI
        ALU_PASS_B
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_NONE,
        BR_EQ,
        BR_NE,
        BR_LT,
        BR_GE,
        BR_JAL
    } br_type_e;

    typedef struct packed {
        logic   valid;
        xlen_t  pc;
        instr_t instr;
    } fetch_out_t;

    typedef struct packed {
        logic     valid;
        xlen_t    pc;
        alu_op_e  alu_op;
        br_type_e br_type;
        reg_idx_t rs1;
        reg_idx_t rs2;
        logic     use_imm;
        xlen_t    imm;
        reg_idx_t rd;
        logic     wb_en;
    } dec_op_t;

    typedef struct packed {
        logic     valid;
        xlen_t    pc;
        alu_op_e  alu_op;
        br_type_e br_type;
        xlen_t    op_a;
        xlen_t    op_b;
        // rs2 value, compared against op_a by branches
        xlen_t    cmp;
        xlen_t    imm;
        reg_idx_t rd;
        logic     wb_en;
    } issue_op_t;

    typedef struct packed {
        logic     valid;
        xlen_t    pc;
        reg_idx_t rd;
        logic     wb_en;
        xlen_t    data;
    } retire_t;

    typedef struct packed {
        logic  valid;
        xlen_t pc;
    } redirect_t;

endpackage

//--- rv_fetch.sv
`include "rv_defs.svh"

module rv_fetch
    import rv_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  redirect_t  redirect,
    output xlen_t      im_req_addr,
    output logic       im_req_valid,
    input  logic       im_req_ready,
    input  instr_t     im_resp_rdata,
    input  logic       im_resp_valid,
    output fetch_out_t fetch_out
);

    xlen_t pc;
    xlen_t pc_next;
    xlen_t req_addr;
    logic  req_valid;
    // Request accepted, response not yet back
    logic  pending;
    // Outstanding response belongs to a flushed path
    logic  drop;
    logic  resp_in;
    logic  resp_ok;
    logic  raise;

    assign resp_in = pending && im_resp_valid;
    assign resp_ok = resp_in && !drop;
    // New request right after a response, or once out of reset
    assign raise   = resp_in || (!req_valid && !pending);

    always_comb begin
        pc_next = pc;
        if (redirect.valid) begin
            pc_next = redirect.pc;
        end else if (resp_ok) begin
            pc_next = req_addr + xlen_t'(4);
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc        <= `RV_RESET_PC;
            req_addr  <= `RV_RESET_PC;
            req_valid <= 1'b0;
            pending   <= 1'b0;
            drop      <= 1'b0;
            fetch_out <= '0;
        end else begin
            pc <= pc_next;

            // Address is frozen while the request waits for ready
            if (raise) begin
                req_valid <= 1'b1;
                req_addr  <= pc_next;
            end else if (req_valid && im_req_ready) begin
                req_valid <= 1'b0;
            end

            if (req_valid && im_req_ready) begin
                pending <= 1'b1;
            end else if (resp_in) begin
                pending <= 1'b0;
            end

            if (redirect.valid) begin
                drop <= req_valid || (pending && !im_resp_valid);
            end else if (resp_in) begin
                drop <= 1'b0;
            end

            fetch_out.valid <= resp_ok && !redirect.valid;
            if (resp_in) begin
                fetch_out.pc    <= req_addr;
                fetch_out.instr <= im_resp_rdata;
            end
        end
    end

    assign im_req_addr  = req_addr;
    assign im_req_valid = req_valid;

endmodule

//--- rv_decode.sv
module rv_decode
    import rv_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  fetch_out_t fetch_in,
    input  redirect_t  redirect,
    output dec_op_t    dec_op
);

    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    instr_t     ins;
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       alt;
    logic       rd_nz;
    logic       reg_legal;
    logic       imm_legal;
    alu_op_e    alu_sel;
    xlen_t      imm_i;
    xlen_t      imm_u;
    xlen_t      imm_b;
    xlen_t      imm_j;
    dec_op_t    dec_next;

    assign ins    = fetch_in.instr;
    assign opcode = ins[6:0];
    assign funct3 = ins[14:12];
    assign alt    = ins[30];
    assign rd_nz  = (ins[11:7] != '0);

    assign imm_i = {{52{ins[31]}}, ins[31:20]};
    assign imm_u = {{32{ins[31]}}, ins[31:12], 12'b0};
    assign imm_b = {{51{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
    assign imm_j = {{43{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};

    // funct7 may only carry the alternate bit on SUB and SRA
    assign reg_legal = (ins[31:25] == 7'b0000000) ||
                       (ins[31:25] == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));

    // RV64 shifts take a 6-bit shamt, so funct6 is checked here
    always_comb begin
        imm_legal = 1'b1;
        if (funct3 == 3'b001) begin
            imm_legal = (ins[31:26] == 6'b000000);
        end else if (funct3 == 3'b101) begin
            imm_legal = (ins[31:26] == 6'b000000) || (ins[31:26] == 6'b010000);
        end
    end

    // Shared ALU selection for OP and OP-IMM
    always_comb begin
        case (funct3)
            3'b000:  alu_sel = (opcode == OPC_OP && alt) ? ALU_SUB : ALU_ADD;
            3'b001:  alu_sel = ALU_SLL;
            3'b010:  alu_sel = ALU_SLT;
            3'b011:  alu_sel = ALU_SLTU;
            3'b100:  alu_sel = ALU_XOR;
            3'b101:  alu_sel = alt ? ALU_SRA : ALU_SRL;
            3'b110:  alu_sel = ALU_OR;
            default: alu_sel = ALU_AND;
        endcase
    end

    always_comb begin
        dec_next         = '0;
        dec_next.valid   = fetch_in.valid;
        dec_next.pc      = fetch_in.pc;
        dec_next.alu_op  = ALU_ADD;
        dec_next.br_type = BR_NONE;
        dec_next.rs1     = ins[19:15];
        dec_next.rs2     = ins[24:20];
        dec_next.rd      = ins[11:7];
        // Unknown encodings fall through as a no-op
        case (opcode)
            OPC_OP_IMM: begin
                if (imm_legal) begin
                    dec_next.alu_op  = alu_sel;
                    dec_next.use_imm = 1'b1;
                    dec_next.imm     = imm_i;
                    dec_next.wb_en   = rd_nz;
                end
            end
            OPC_OP: begin
                if (reg_legal) begin
                    dec_next.alu_op = alu_sel;
                    dec_next.wb_en  = rd_nz;
                end
            end
            OPC_LUI: begin
                dec_next.alu_op  = ALU_PASS_B;
                dec_next.use_imm = 1'b1;
                dec_next.imm     = imm_u;
                dec_next.wb_en   = rd_nz;
            end
            OPC_BRANCH: begin
                dec_next.imm = imm_b;
                case (funct3)
                    3'b000:  dec_next.br_type = BR_EQ;
                    3'b001:  dec_next.br_type = BR_NE;
                    3'b100:  dec_next.br_type = BR_LT;
                    3'b101:  dec_next.br_type = BR_GE;
                    default: dec_next.br_type = BR_NONE;
                endcase
            end
            OPC_JAL: begin
                dec_next.br_type = BR_JAL;
                dec_next.imm     = imm_j;
                dec_next.wb_en   = rd_nz;
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dec_op <= '0;
        end else begin
            dec_op <= dec_next;
            if (redirect.valid) begin
                dec_op.valid <= 1'b0;
            end
        end
    end

endmodule

//--- rv_issue.sv
module rv_issue
    import rv_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  dec_op_t   dec_in,
    input  redirect_t redirect,
    output reg_idx_t  rf_raddr_a,
    output reg_idx_t  rf_raddr_b,
    input  xlen_t     rf_rdata_a,
    input  xlen_t     rf_rdata_b,
    input  retire_t   fwd,
    output issue_op_t issue_op
);

    logic      fwd_a;
    logic      fwd_b;
    xlen_t     rs1_val;
    xlen_t     rs2_val;
    issue_op_t issue_next;

    assign rf_raddr_a = dec_in.rs1;
    assign rf_raddr_b = dec_in.rs2;

    // Result in the retire register has not reached the register file yet
    // wb_en is never set for x0, so x0 is never bypassed
    assign fwd_a = fwd.valid && fwd.wb_en && (fwd.rd == dec_in.rs1);
    assign fwd_b = fwd.valid && fwd.wb_en && (fwd.rd == dec_in.rs2);

    assign rs1_val = fwd_a ? fwd.data : rf_rdata_a;
    assign rs2_val = fwd_b ? fwd.data : rf_rdata_b;

    always_comb begin
        issue_next.valid   = dec_in.valid;
        issue_next.pc      = dec_in.pc;
        issue_next.alu_op  = dec_in.alu_op;
        issue_next.br_type = dec_in.br_type;
        issue_next.op_a    = rs1_val;
        issue_next.op_b    = dec_in.use_imm ? dec_in.imm : rs2_val;
        issue_next.cmp     = rs2_val;
        issue_next.imm     = dec_in.imm;
        issue_next.rd      = dec_in.rd;
        issue_next.wb_en   = dec_in.wb_en;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            issue_op <= '0;
        end else begin
            issue_op <= issue_next;
            // Op in decode is younger than the redirecting branch
            if (redirect.valid) begin
                issue_op.valid <= 1'b0;
            end
        end
    end

endmodule

//--- rv_regfile.sv
module rv_regfile
    import rv_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,
    input  reg_idx_t raddr_a,
    input  reg_idx_t raddr_b,
    output xlen_t    rdata_a,
    output xlen_t    rdata_b,
    input  retire_t  wr
);

    localparam int NREGS = 2 ** $bits(reg_idx_t);

    xlen_t regs [NREGS];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.valid && wr.wb_en && wr.rd != '0) begin
            regs[wr.rd] <= wr.data;
        end
    end

    // x0 reads as zero
    assign rdata_a = (raddr_a == '0) ? '0 : regs[raddr_a];
    assign rdata_b = (raddr_b == '0) ? '0 : regs[raddr_b];

endmodule

//--- rv_int_pipe.sv
module rv_int_pipe
    import rv_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  issue_op_t issue_in,
    output retire_t   retire,
    output redirect_t redirect
);

    xlen_t      a;
    xlen_t      b;
    logic [5:0] shamt;
    xlen_t      alu_res;
    xlen_t      result;
    logic       taken;
    logic       fire;

    assign a     = issue_in.op_a;
    assign b     = issue_in.op_b;
    assign shamt = b[5:0];

    always_comb begin
        case (issue_in.alu_op)
            ALU_ADD:    alu_res = a + b;
            ALU_SUB:    alu_res = a - b;
            ALU_AND:    alu_res = a & b;
            ALU_OR:     alu_res = a | b;
            ALU_XOR:    alu_res = a ^ b;
            ALU_SLT:    alu_res = xlen_t'($signed(a) < $signed(b));
            ALU_SLTU:   alu_res = xlen_t'(a < b);
            ALU_SLL:    alu_res = a << shamt;
            ALU_SRL:    alu_res = a >> shamt;
            ALU_SRA:    alu_res = $signed(a) >>> shamt;
            ALU_PASS_B: alu_res = b;
            default:    alu_res = a + b;
        endcase
    end

    // Branch condition on rs1 against rs2
    always_comb begin
        case (issue_in.br_type)
            BR_EQ:   taken = (a == issue_in.cmp);
            BR_NE:   taken = (a != issue_in.cmp);
            BR_LT:   taken = ($signed(a) < $signed(issue_in.cmp));
            BR_GE:   taken = ($signed(a) >= $signed(issue_in.cmp));
            BR_JAL:  taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    // Link address for JAL
    assign result = (issue_in.br_type == BR_JAL) ? issue_in.pc + xlen_t'(4) : alu_res;

    // Anything issued next to a redirect is on the flushed path
    assign fire = issue_in.valid && !redirect.valid;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            retire   <= '0;
            redirect <= '0;
        end else begin
            retire.valid <= fire;
            retire.pc    <= issue_in.pc;
            retire.rd    <= issue_in.rd;
            retire.wb_en <= issue_in.wb_en;
            retire.data  <= result;

            redirect.valid <= fire && taken;
            redirect.pc    <= issue_in.pc + issue_in.imm;
        end
    end

endmodule

//--- rv_core.sv
module rv_core
    import rv_pkg::*;
(
    input  logic    clk,
    input  logic    arst_n,
    // Instruction memory
    output xlen_t   im_req_addr,
    output logic    im_req_valid,
    input  logic    im_req_ready,
    input  instr_t  im_resp_rdata,
    input  logic    im_resp_valid,
    // Trace of completed instructions
    output retire_t retire
);

    fetch_out_t if_dec;
    dec_op_t    dec_ix;
    issue_op_t  ix_ip;
    redirect_t  redirect;
    reg_idx_t   rf_raddr_a;
    reg_idx_t   rf_raddr_b;
    xlen_t      rf_rdata_a;
    xlen_t      rf_rdata_b;

    rv_fetch u_fetch (
        .clk          (clk),
        .arst_n       (arst_n),
        .redirect     (redirect),
        .im_req_addr  (im_req_addr),
        .im_req_valid (im_req_valid),
        .im_req_ready (im_req_ready),
        .im_resp_rdata(im_resp_rdata),
        .im_resp_valid(im_resp_valid),
        .fetch_out    (if_dec)
    );

    rv_decode u_decode (
        .clk     (clk),
        .arst_n  (arst_n),
        .fetch_in(if_dec),
        .redirect(redirect),
        .dec_op  (dec_ix)
    );

    // Retire record doubles as the bypass source
    rv_issue u_issue (
        .clk       (clk),
        .arst_n    (arst_n),
        .dec_in    (dec_ix),
        .redirect  (redirect),
        .rf_raddr_a(rf_raddr_a),
        .rf_raddr_b(rf_raddr_b),
        .rf_rdata_a(rf_rdata_a),
        .rf_rdata_b(rf_rdata_b),
        .fwd       (retire),
        .issue_op  (ix_ip)
    );

    rv_regfile u_regfile (
        .clk    (clk),
        .arst_n (arst_n),
        .raddr_a(rf_raddr_a),
        .raddr_b(rf_raddr_b),
        .rdata_a(rf_rdata_a),
        .rdata_b(rf_rdata_b),
        .wr     (retire)
    );

    rv_int_pipe u_int_pipe (
        .clk     (clk),
        .arst_n  (arst_n),
        .issue_in(ix_ip),
        .retire  (retire),
        .redirect(redirect)
    );

endmodule

//--- tb_rv_core.sv
`include "rv_defs.svh"

module tb_rv_core
    import rv_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int PROG_WORDS = 41;

    typedef struct packed {
        xlen_t    pc;
        reg_idx_t rd;
        logic     wb_en;
        // rd and data carry meaning only for non-branch ops
        logic     chk;
        xlen_t    data;
    } exp_t;

    logic    clk;
    logic    arst_n;
    xlen_t   im_req_addr;
    logic    im_req_valid;
    logic    im_req_ready;
    instr_t  im_resp_rdata;
    logic    im_resp_valid;
    retire_t retire;

    instr_t      prog [PROG_WORDS];
    exp_t        expect_q[$];
    int          cycle_limit;
    int          cycles;
    int unsigned seed_init;

    // Request tracking shared by the bus monitor and the memory model
    logic  accept_now;
    xlen_t acc_addr;
    logic  outstanding;
    logic  prev_valid;
    logic  prev_accept;
    xlen_t prev_addr;
    xlen_t next_addr;
    logic  target_pending;
    xlen_t target_pc;

    rv_core u_dut (
        .clk          (clk),
        .arst_n       (arst_n),
        .im_req_addr  (im_req_addr),
        .im_req_valid (im_req_valid),
        .im_req_ready (im_req_ready),
        .im_resp_rdata(im_resp_rdata),
        .im_resp_valid(im_resp_valid),
        .retire       (retire)
    );

    function automatic instr_t reg_op(input logic [6:0] funct7, input logic [2:0] funct3,
                                      input int rd, input int rs1, input int rs2);
        return {funct7, reg_idx_t'(rs2), reg_idx_t'(rs1), funct3, reg_idx_t'(rd), 7'b0110011};
    endfunction

    function automatic instr_t imm_op(input logic [2:0] funct3, input int rd, input int rs1,
                                      input int imm);
        return {12'(imm), reg_idx_t'(rs1), funct3, reg_idx_t'(rd), 7'b0010011};
    endfunction

    function automatic instr_t lui_word(input int rd, input int imm);
        return {20'(imm), reg_idx_t'(rd), 7'b0110111};
    endfunction

    function automatic instr_t branch_word(input logic [2:0] funct3, input int rs1,
                                           input int rs2, input int off);
        logic [12:0] o;
        o = 13'(off);
        return {o[12], o[10:5], reg_idx_t'(rs2), reg_idx_t'(rs1), funct3, o[4:1], o[11],
                7'b1100011};
    endfunction

    function automatic instr_t jal_word(input int rd, input int off);
        logic [20:0] o;
        o = 21'(off);
        return {o[20], o[10:1], o[11], o[19:12], reg_idx_t'(rd), 7'b1101111};
    endfunction

    // Addresses past the program return an ADDI to x0 tagged with the word address
    function automatic instr_t fetch_word(input xlen_t addr);
        int idx;
        idx = int'(addr >> 2);
        if (addr < xlen_t'(PROG_WORDS * 4)) begin
            return prog[idx];
        end
        return imm_op(3'b000, 0, 0, int'(addr[13:2]));
    endfunction

    task automatic add_expect(input int idx, input int rd, input logic wb_en, input logic chk,
                              input xlen_t data);
        exp_t e;
        e.pc    = `RV_RESET_PC + xlen_t'(idx * 4);
        e.rd    = reg_idx_t'(rd);
        e.wb_en = wb_en;
        e.chk   = chk;
        e.data  = data;
        expect_q.push_back(e);
    endtask

    task automatic abort_run(input string msg);
        $display("ERROR: time %0d ns: %s", $time, msg);
        $display("Simulation FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic mismatch(input string name, input xlen_t exp_val, input xlen_t act_val);
        $display("ERROR: time %0d ns: %s expected 0x%h, actual 0x%h",
                 $time, name, exp_val, act_val);
        $display("Simulation FAILED");
        $fatal(1, "run stopped");
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Instruction memory with random ready and 1 to 3 cycles of latency
    initial begin
        logic   busy;
        int     lat_left;
        instr_t resp_word;
        busy          = 1'b0;
        lat_left      = 0;
        resp_word     = '0;
        im_req_ready  = 1'b0;
        im_resp_valid = 1'b0;
        im_resp_rdata = '0;
        forever begin
            @(posedge clk);
            #2;
            im_req_ready  = ($urandom % 3) != 0;
            im_resp_valid = 1'b0;
            if (accept_now) begin
                busy      = 1'b1;
                lat_left  = 1 + int'($urandom % 3);
                resp_word = fetch_word(acc_addr);
            end
            if (busy) begin
                lat_left--;
                if (lat_left == 0) begin
                    im_resp_valid = 1'b1;
                    im_resp_rdata = resp_word;
                    busy          = 1'b0;
                end
            end
        end
    end

    // Request bus monitor sampled mid-cycle
    always @(negedge clk) begin
        accept_now = 1'b0;
        if (arst_n) begin
            if (prev_valid && !prev_accept) begin
                assert (im_req_valid && im_req_addr == prev_addr)
                else abort_run("request dropped or address changed before acceptance");
            end
            assert (!(im_req_valid && outstanding))
            else abort_run("new request raised while a response was still outstanding");
            accept_now = im_req_valid && im_req_ready;
            acc_addr   = im_req_addr;
            if (accept_now) begin
                if (target_pending && im_req_addr == target_pc) begin
                    target_pending = 1'b0;
                end else begin
                    assert (im_req_addr == next_addr)
                    else mismatch("im_req_addr", next_addr, im_req_addr);
                end
                next_addr = im_req_addr + 64'd4;
            end
            if (im_resp_valid) begin
                outstanding = 1'b0;
            end
            if (accept_now) begin
                outstanding = 1'b1;
            end
            prev_valid  = im_req_valid;
            prev_addr   = im_req_addr;
            prev_accept = accept_now;
        end
    end

    always @(posedge clk) begin
        if (arst_n) begin
            cycles++;
            if (cycles > cycle_limit) begin
                abort_run("timeout, retire sequence did not complete");
            end
        end
    end

    initial begin
        exp_t e;
        int   n;
        seed_init      = $urandom(67732);
        arst_n         = 1'b0;
        cycles         = 0;
        accept_now     = 1'b0;
        acc_addr       = '0;
        outstanding    = 1'b0;
        prev_valid     = 1'b0;
        prev_accept    = 1'b0;
        prev_addr      = '0;
        next_addr      = `RV_RESET_PC;
        target_pending = 1'b0;
        target_pc      = '0;

        prog[0]  = imm_op(3'b000, 1, 0, 5);
        prog[1]  = imm_op(3'b000, 2, 0, -3);
        prog[2]  = reg_op(7'b0000000, 3'b000, 3, 1, 2);
        prog[3]  = reg_op(7'b0100000, 3'b000, 4, 3, 1);
        prog[4]  = lui_word(5, 'h80000);
        prog[5]  = imm_op(3'b101, 6, 5, 'h404);
        prog[6]  = imm_op(3'b101, 7, 5, 60);
        prog[7]  = imm_op(3'b001, 8, 1, 33);
        prog[8]  = reg_op(7'b0000000, 3'b010, 9, 2, 1);
        prog[9]  = reg_op(7'b0000000, 3'b011, 10, 2, 1);
        prog[10] = imm_op(3'b100, 11, 2, 'h0f);
        prog[11] = imm_op(3'b110, 12, 1, 'h30);
        prog[12] = imm_op(3'b111, 13, 2, 'h7f);
        prog[13] = reg_op(7'b0000000, 3'b111, 14, 6, 5);
        prog[14] = reg_op(7'b0000000, 3'b110, 15, 13, 12);
        prog[15] = reg_op(7'b0000000, 3'b001, 16, 1, 1);
        prog[16] = reg_op(7'b0000000, 3'b101, 17, 5, 1);
        prog[17] = reg_op(7'b0100000, 3'b101, 18, 5, 1);
        prog[18] = reg_op(7'b0000000, 3'b100, 19, 18, 17);
        prog[19] = imm_op(3'b000, 0, 1, 7);
        prog[20] = reg_op(7'b0000000, 3'b000, 20, 0, 1);
        // Skipped slots in the branch section write x21 and must never retire
        prog[21] = branch_word(3'b000, 1, 20, 12);
        prog[22] = imm_op(3'b000, 21, 0, 1);
        prog[23] = imm_op(3'b000, 21, 0, 2);
        prog[24] = branch_word(3'b001, 1, 20, 12);
        prog[25] = branch_word(3'b001, 1, 2, 12);
        prog[26] = imm_op(3'b000, 21, 0, 3);
        prog[27] = imm_op(3'b000, 21, 0, 4);
        prog[28] = branch_word(3'b100, 2, 1, 12);
        prog[29] = imm_op(3'b000, 21, 0, 5);
        prog[30] = imm_op(3'b000, 21, 0, 6);
        prog[31] = branch_word(3'b100, 1, 2, 12);
        prog[32] = branch_word(3'b101, 1, 2, 12);
        prog[33] = imm_op(3'b000, 21, 0, 7);
        prog[34] = imm_op(3'b000, 21, 0, 8);
        prog[35] = branch_word(3'b101, 2, 1, 12);
        prog[36] = jal_word(22, 12);
        prog[37] = imm_op(3'b000, 22, 0, 9);
        prog[38] = imm_op(3'b000, 22, 0, 10);
        prog[39] = reg_op(7'b0000000, 3'b000, 23, 22, 1);
        prog[40] = jal_word(0, 0);

        add_expect(0, 1, 1'b1, 1'b1, 64'h0000_0000_0000_0005);
        add_expect(1, 2, 1'b1, 1'b1, 64'hffff_ffff_ffff_fffd);
        add_expect(2, 3, 1'b1, 1'b1, 64'h0000_0000_0000_0002);
        add_expect(3, 4, 1'b1, 1'b1, 64'hffff_ffff_ffff_fffd);
        add_expect(4, 5, 1'b1, 1'b1, 64'hffff_ffff_8000_0000);
        add_expect(5, 6, 1'b1, 1'b1, 64'hffff_ffff_f800_0000);
        add_expect(6, 7, 1'b1, 1'b1, 64'h0000_0000_0000_000f);
        add_expect(7, 8, 1'b1, 1'b1, 64'h0000_000a_0000_0000);
        add_expect(8, 9, 1'b1, 1'b1, 64'h0000_0000_0000_0001);
        add_expect(9, 10, 1'b1, 1'b1, 64'h0000_0000_0000_0000);
        add_expect(10, 11, 1'b1, 1'b1, 64'hffff_ffff_ffff_fff2);
        add_expect(11, 12, 1'b1, 1'b1, 64'h0000_0000_0000_0035);
        add_expect(12, 13, 1'b1, 1'b1, 64'h0000_0000_0000_007d);
        add_expect(13, 14, 1'b1, 1'b1, 64'hffff_ffff_8000_0000);
        add_expect(14, 15, 1'b1, 1'b1, 64'h0000_0000_0000_007d);
        add_expect(15, 16, 1'b1, 1'b1, 64'h0000_0000_0000_00a0);
        add_expect(16, 17, 1'b1, 1'b1, 64'h07ff_ffff_fc00_0000);
        add_expect(17, 18, 1'b1, 1'b1, 64'hffff_ffff_fc00_0000);
        add_expect(18, 19, 1'b1, 1'b1, 64'hf800_0000_0000_0000);
        add_expect(19, 0, 1'b0, 1'b1, 64'h0000_0000_0000_000c);
        add_expect(20, 20, 1'b1, 1'b1, 64'h0000_0000_0000_0005);
        add_expect(21, 0, 1'b0, 1'b0, '0);
        add_expect(24, 0, 1'b0, 1'b0, '0);
        add_expect(25, 0, 1'b0, 1'b0, '0);
        add_expect(28, 0, 1'b0, 1'b0, '0);
        add_expect(31, 0, 1'b0, 1'b0, '0);
        add_expect(32, 0, 1'b0, 1'b0, '0);
        add_expect(35, 0, 1'b0, 1'b0, '0);
        add_expect(36, 22, 1'b1, 1'b1, 64'h0000_0000_0000_0094);
        add_expect(39, 23, 1'b1, 1'b1, 64'h0000_0000_0000_0099);
        add_expect(40, 0, 1'b0, 1'b1, 64'h0000_0000_0000_00a4);
        add_expect(40, 0, 1'b0, 1'b1, 64'h0000_0000_0000_00a4);

        n           = expect_q.size();
        cycle_limit = 20 * n + 50;

        repeat (4) @(posedge clk);
        #2;
        // Request and retire stay idle while in reset
        assert (!im_req_valid && !retire.valid)
        else abort_run("request or retire valid while reset was asserted");
        arst_n = 1'b1;

        for (int i = 0; i < n; i++) begin
            e = expect_q[i];
            do begin
                @(negedge clk);
            end while (!retire.valid);
            assert (retire.pc == e.pc) else mismatch("retire.pc", e.pc, retire.pc);
            assert (retire.wb_en == e.wb_en)
            else mismatch("retire.wb_en", xlen_t'(e.wb_en), xlen_t'(retire.wb_en));
            if (e.chk) begin
                assert (retire.rd == e.rd)
                else mismatch("retire.rd", xlen_t'(e.rd), xlen_t'(retire.rd));
                assert (retire.data == e.data)
                else mismatch("retire.data", e.data, retire.data);
            end
            // A jump in the retire PCs means the next fetch goes to the target
            if (i + 1 < n && expect_q[i + 1].pc != e.pc + 64'd4) begin
                target_pc      = expect_q[i + 1].pc;
                target_pending = 1'b1;
            end
        end

        $display("Simulation PASSED");
        $finish;
    end

endmodule

//--- sources.f
+incdir+.
rv_pkg.sv
rv_fetch.sv
rv_decode.sv
rv_issue.sv
rv_regfile.sv
rv_int_pipe.sv
rv_core.sv
tb_rv_core.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the rv_core testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary \
    --timescale 1ns/1ps \
    --top-module tb_rv_core \
    -f sources.f \
    -o sim_tb_rv_core

./obj_dir/sim_tb_rv_core
